//--- verilog/acq_pkg.sv
package acq_pkg;

    //////////////////////////////////////////////////
    // sample data

    // two adc samples with their over-range bits, second sample on top
    typedef struct packed {
        logic        ovr1;      // second over-range
        logic [11:0] sample1;   // second adc sample
        logic        ovr0;      // first over-range
        logic [11:0] sample0;   // first adc sample
    } sample_pair_t;

    // static configuration, only changed while idle
    typedef struct packed {
        logic [11:0] channel_tag;       // channel info for the header
        logic [13:0] num_bursts;        // data words per waveform
        logic [23:0] initial_fill_num;  // loaded on fill_num_wr
    } acq_cfg_t;

    //////////////////////////////////////////////////
    // output words

    // what a 128-bit output word carries
    typedef enum logic [3:0] {
        tag_wfm_hdr = 4'h1,     // waveform header
        tag_data    = 4'h2      // eight packed samples
    } word_tag_e;

    typedef struct packed {
        word_tag_e    tag;
        logic [127:0] payload;
    } out_word_t;

    // waveform header payload layout
    typedef struct packed {
        logic [49:0] rsvd;          // always zero
        logic [15:0] trig_addr;     // buffer address of the trigger point
        logic [13:0] num_bursts;    // data words that follow
        logic [11:0] wfm_num;       // waveform number within the fill
        logic [23:0] fill_num;      // current fill
        logic [11:0] channel_tag;   // from cfg
    } wfm_hdr_t;

    //////////////////////////////////////////////////
    // readout fsm

    typedef enum logic [2:0] {
        st_idle,    // wait for a queued trigger
        st_pop,     // latch trigger, set start address
        st_hdr,     // send waveform header
        st_load,    // four pair reads
        st_emit,    // one data word out
        st_done     // waveform finished
    } rd_state_e;

endpackage

//--- verilog/acq_ctrl_sync.sv
module acq_ctrl_sync (
    input  logic adc_clk,
    input  logic arst_n,
    input  logic acq_enable,    // async level
    input  logic acq_trig,      // async level
    output logic wr_en,         // enable in adc_clk domain
    output logic trig_pulse     // one cycle per rising trigger
);

    logic [2:0] en_sync;    // enable synchronizer chain
    logic [5:0] trig_sync;  // trigger chain, bit 5 is the delayed copy for edge detect

    //////////////////////////////////////////////////
    // enable synchronizer, three flops
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            en_sync <= '0;
        end else begin
            en_sync <= {en_sync[1:0], acq_enable};
        end
    end

    assign wr_en = en_sync[2];

    //////////////////////////////////////////////////
    // trigger synchronizer and rising edge pulse
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_sync  <= '0;
            trig_pulse <= 1'b0;
        end else begin
            trig_sync  <= {trig_sync[4:0], acq_trig};
            // edge seen at the fifth flop, dropped while disabled
            trig_pulse <= trig_sync[4] & ~trig_sync[5] & wr_en;
        end
    end

endmodule

//--- verilog/sample_cbuf.sv
module sample_cbuf #(
    parameter int CBUF_AW = 16      // buffer depth is 2**CBUF_AW pairs
) (
    input  logic                 adc_clk,
    input  logic                 arst_n,
    input  logic                 wr_en,         // write one pair per cycle
    input  acq_pkg::sample_pair_t sample_in,
    output logic [CBUF_AW-1:0]   wr_addr,       // next location to write
    input  logic [CBUF_AW-1:0]   rd_addr,
    output acq_pkg::sample_pair_t rd_data       // one cycle after rd_addr
);

    localparam int DEPTH = 2**CBUF_AW;

    acq_pkg::sample_pair_t mem [DEPTH];     // dual-port sample store

    //////////////////////////////////////////////////
    // write address, free running while enabled
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;  // wraps at depth
        end
    end

    //////////////////////////////////////////////////
    // memory ports
    always_ff @(posedge adc_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= sample_in;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge adc_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/trig_addr_fifo.sv
module trig_addr_fifo #(
    parameter int CBUF_AW = 16,     // width of a stored address
    parameter int FIFO_AW = 4       // depth is 2**FIFO_AW
) (
    input  logic               adc_clk,
    input  logic               arst_n,
    input  logic               push,    // trigger pulse
    input  logic [CBUF_AW-1:0] din,     // write address at the trigger
    input  logic               pop,
    output logic [CBUF_AW-1:0] dout,    // head entry, valid while !empty
    output logic               empty
);

    localparam int DEPTH = 2**FIFO_AW;

    logic [CBUF_AW-1:0] mem [DEPTH];    // queued trigger addresses
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;          // entries held
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (FIFO_AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;      // push into full fifo is lost
    assign do_pop  = pop & ~empty;

    // fall-through head
    assign dout = mem[rd_ptr];

    always_ff @(posedge adc_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    //////////////////////////////////////////////////
    // pointers and fill count
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or both at once
            endcase
        end
    end

endmodule

//--- verilog/readout_sm.sv
module readout_sm #(
    parameter int CBUF_AW = 16
) (
    input  logic                 adc_clk,
    input  logic                 arst_n,
    input  logic                 wr_en,         // acquisition enabled
    input  logic [CBUF_AW-1:0]   trig_addr,     // fifo head
    input  logic                 empty,         // no trigger queued
    input  acq_pkg::acq_cfg_t    cfg,
    input  logic                 fill_num_wr,   // load initial fill number
    input  logic [CBUF_AW-1:0]   pre_trig,      // pairs before the trigger point
    output logic                 pop,
    output logic [CBUF_AW-1:0]   rd_addr,
    output logic                 shift,         // rd_data valid for the pair chain
    output logic                 sel_hdr,
    output logic                 sel_data,
    output logic [15:0]          latched_trig,  // zero-extended trigger address
    output logic [11:0]          wfm_num,
    output logic [23:0]          fill_num,
    output logic                 acq_done,
    output logic                 sm_idle
);

    acq_pkg::rd_state_e state;
    acq_pkg::rd_state_e state_nxt;

    logic [13:0] burst_cnt;     // data words still to send
    logic [1:0]  load_cnt;      // pair reads within one word
    logic        enabled_q;     // wr_en one cycle late, covers a trigger still in flight
    logic        fill_active;   // acquisition seen since last fill end
    logic        fill_end;

    // fill finishes once disabled, drained and idle
    assign fill_end = (state == acq_pkg::st_idle) && empty && !wr_en && !enabled_q
                      && fill_active;

    assign pop     = (state == acq_pkg::st_pop);
    assign sel_hdr = (state == acq_pkg::st_hdr);
    assign sm_idle = (state == acq_pkg::st_idle);

    //////////////////////////////////////////////////
    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            acq_pkg::st_idle: begin
                if (!empty) state_nxt = acq_pkg::st_pop;
            end
            acq_pkg::st_pop: begin
                state_nxt = acq_pkg::st_hdr;
            end
            acq_pkg::st_hdr: begin
                // header only when no data words are asked for
                if (cfg.num_bursts == '0) state_nxt = acq_pkg::st_done;
                else                      state_nxt = acq_pkg::st_load;
            end
            acq_pkg::st_load: begin
                if (load_cnt == 2'd3) state_nxt = acq_pkg::st_emit;
            end
            acq_pkg::st_emit: begin
                if (burst_cnt == 14'd1) state_nxt = acq_pkg::st_done;
                else                    state_nxt = acq_pkg::st_load;
            end
            acq_pkg::st_done: begin
                state_nxt = acq_pkg::st_idle;
            end
            default: begin
                state_nxt = acq_pkg::st_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // state, counters and strobes
    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= acq_pkg::st_idle;
            burst_cnt   <= '0;
            load_cnt    <= '0;
            rd_addr     <= '0;
            wfm_num     <= '0;
            fill_num    <= '0;
            enabled_q   <= 1'b0;
            fill_active <= 1'b0;
            acq_done    <= 1'b0;
            shift       <= 1'b0;
            sel_data    <= 1'b0;
        end else begin
            state     <= state_nxt;
            enabled_q <= wr_en;
            acq_done  <= fill_end;      // fill_num steps on the same edge

            // read data trails the address by one cycle
            shift    <= (state == acq_pkg::st_load);
            // word goes out after the fourth pair is in the chain
            sel_data <= (state == acq_pkg::st_emit);

            // load counter, wraps after the fourth read
            if (state == acq_pkg::st_load) load_cnt <= load_cnt + 1'b1;
            else                           load_cnt <= '0;

            if (state == acq_pkg::st_pop) begin
                rd_addr   <= trig_addr - pre_trig;  // modulo buffer depth
                burst_cnt <= cfg.num_bursts;
            end else if (state == acq_pkg::st_load) begin
                rd_addr   <= rd_addr + 1'b1;
            end else if (state == acq_pkg::st_emit) begin
                burst_cnt <= burst_cnt - 1'b1;
            end

            // waveform counter
            if (fill_end)                         wfm_num <= '0;
            else if (state == acq_pkg::st_done)   wfm_num <= wfm_num + 1'b1;

            // fill counter
            if (fill_num_wr)   fill_num <= cfg.initial_fill_num;
            else if (fill_end) fill_num <= fill_num + 1'b1;

            if (fill_end)   fill_active <= 1'b0;
            else if (wr_en) fill_active <= 1'b1;
        end
    end

    // trigger point of the waveform in progress, for the header
    always_ff @(posedge adc_clk) begin
        if (state == acq_pkg::st_pop) begin
            latched_trig <= 16'(trig_addr);
        end
    end

endmodule

//--- verilog/word_pack.sv
module word_pack (
    input  logic                  adc_clk,
    input  logic                  arst_n,
    input  acq_pkg::sample_pair_t rd_data,      // pair from the buffer
    input  logic                  shift,        // take rd_data into the chain
    input  logic                  sel_hdr,      // register a header word
    input  logic                  sel_data,     // register a data word
    input  acq_pkg::acq_cfg_t     cfg,
    input  logic [23:0]           fill_num,
    input  logic [11:0]           wfm_num,
    input  logic [15:0]           latched_trig,
    output acq_pkg::out_word_t    out_word,
    output logic                  out_valid     // push strobe, no ready
);

    acq_pkg::sample_pair_t pair_q [4];  // [0] holds the oldest pair
    acq_pkg::wfm_hdr_t     hdr;
    logic [127:0]          data_lanes;

    //////////////////////////////////////////////////
    // pair shift chain, new pair enters at the top
    always_ff @(posedge adc_clk) begin
        if (shift) begin
            pair_q[3] <= rd_data;
            pair_q[2] <= pair_q[3];
            pair_q[1] <= pair_q[2];
            pair_q[0] <= pair_q[1];
        end
    end

    // each pair zero-extended into a 32-bit lane, oldest lowest
    assign data_lanes = {6'b0, pair_q[3],
                         6'b0, pair_q[2],
                         6'b0, pair_q[1],
                         6'b0, pair_q[0]};

    //////////////////////////////////////////////////
    // header fields
    always_comb begin
        hdr             = '0;           // reserved bits stay zero
        hdr.trig_addr   = latched_trig;
        hdr.num_bursts  = cfg.num_bursts;
        hdr.wfm_num     = wfm_num;
        hdr.fill_num    = fill_num;
        hdr.channel_tag = cfg.channel_tag;
    end

    //////////////////////////////////////////////////
    // output register with tag
    always_ff @(posedge adc_clk) begin
        if (sel_hdr) begin
            out_word.tag     <= acq_pkg::tag_wfm_hdr;
            out_word.payload <= hdr;
        end else if (sel_data) begin
            out_word.tag     <= acq_pkg::tag_data;
            out_word.payload <= data_lanes;
        end
    end

    always_ff @(posedge adc_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sel_hdr | sel_data;    // strobes never overlap
        end
    end

endmodule

//--- verilog/adc_acq_top.sv
module adc_acq_top #(
    parameter int CBUF_AW = 16,     // circular buffer address width
    parameter int FIFO_AW = 4       // trigger fifo depth exponent
) (
    input  logic                  adc_clk,
    input  logic                  arst_n,
    input  acq_pkg::sample_pair_t sample_in,    // one pair per cycle
    input  logic                  acq_enable,   // async
    input  logic                  acq_trig,     // async
    input  acq_pkg::acq_cfg_t     cfg,
    input  logic                  fill_num_wr,
    input  logic [CBUF_AW-1:0]    pre_trig,
    output acq_pkg::out_word_t    out_word,
    output logic                  out_valid,
    output logic [23:0]           fill_num,
    output logic                  acq_enabled,
    output logic                  acq_done,
    output logic                  sm_idle
);

    logic                  wr_en;           // synchronized enable
    logic                  trig_pulse;
    logic [CBUF_AW-1:0]    wr_addr;         // current trigger point
    logic [CBUF_AW-1:0]    rd_addr;
    acq_pkg::sample_pair_t rd_data;
    logic [CBUF_AW-1:0]    trig_addr;       // fifo head
    logic                  fifo_empty;
    logic                  pop;
    logic                  shift;
    logic                  sel_hdr;
    logic                  sel_data;
    logic [15:0]           latched_trig;
    logic [11:0]           wfm_num;

    assign acq_enabled = wr_en;

    //////////////////////////////////////////////////
    // capture side
    acq_ctrl_sync acq_ctrl_sync (
        .adc_clk    (adc_clk),
        .arst_n     (arst_n),
        .acq_enable (acq_enable),
        .acq_trig   (acq_trig),
        .wr_en      (wr_en),
        .trig_pulse (trig_pulse)
    );

    sample_cbuf #(.CBUF_AW(CBUF_AW)) sample_cbuf (
        .adc_clk   (adc_clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .sample_in (sample_in),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // write address at each trigger is queued here
    trig_addr_fifo #(.CBUF_AW(CBUF_AW), .FIFO_AW(FIFO_AW)) trig_addr_fifo (
        .adc_clk (adc_clk),
        .arst_n  (arst_n),
        .push    (trig_pulse),
        .din     (wr_addr),
        .pop     (pop),
        .dout    (trig_addr),
        .empty   (fifo_empty)
    );

    //////////////////////////////////////////////////
    // readout side
    readout_sm #(.CBUF_AW(CBUF_AW)) readout_sm (
        .adc_clk      (adc_clk),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .trig_addr    (trig_addr),
        .empty        (fifo_empty),
        .cfg          (cfg),
        .fill_num_wr  (fill_num_wr),
        .pre_trig     (pre_trig),
        .pop          (pop),
        .rd_addr      (rd_addr),
        .shift        (shift),
        .sel_hdr      (sel_hdr),
        .sel_data     (sel_data),
        .latched_trig (latched_trig),
        .wfm_num      (wfm_num),
        .fill_num     (fill_num),
        .acq_done     (acq_done),
        .sm_idle      (sm_idle)
    );

    word_pack word_pack (
        .adc_clk      (adc_clk),
        .arst_n       (arst_n),
        .rd_data      (rd_data),
        .shift        (shift),
        .sel_hdr      (sel_hdr),
        .sel_data     (sel_data),
        .cfg          (cfg),
        .fill_num     (fill_num),
        .wfm_num      (wfm_num),
        .latched_trig (latched_trig),
        .out_word     (out_word),
        .out_valid    (out_valid)
    );

endmodule

//--- bench/tb_adc_acq.sv
module tb_adc_acq;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CBUF_AW = 16;

    // dut inputs
    logic                  adc_clk;
    logic                  arst_n;
    acq_pkg::sample_pair_t sample_in;
    logic                  acq_enable;
    logic                  acq_trig;
    acq_pkg::acq_cfg_t     cfg;
    logic                  fill_num_wr;
    logic [CBUF_AW-1:0]    pre_trig;

    // dut outputs
    acq_pkg::out_word_t    out_word;
    logic                  out_valid;
    logic [23:0]           fill_num;
    logic                  acq_enabled;
    logic                  acq_done;
    logic                  sm_idle;

    // ramp source, index mirrors the buffer write address
    integer                seed;
    logic [15:0]           ramp_idx;
    logic                  en_seen = 1'b0;  // write happened at the coming edge
    logic [1:0]            ovr_rec [65536]; // {ovr1, ovr0} per ramp index

    // expected values of the running fill
    logic [11:0]           exp_ch;
    logic [13:0]           exp_nb;
    logic [15:0]           exp_pre;
    int                    exp_spacing;
    int                    exp_ntrig;
    logic [23:0]           exp_fill;
    logic [15:0]           trig_ref;        // ramp index just before the first trigger

    // output monitor state
    int                    hdr_cnt;
    int                    data_left;       // data words still due for this waveform
    int                    done_cnt;
    logic                  fill_open;
    logic [15:0]           last_trig;
    logic [15:0]           next_idx;        // ramp index of the next expected pair
    acq_pkg::wfm_hdr_t     hdr;
    logic [127:0]          exp_payload;
    logic [15:0]           trig_ofs;

    initial adc_clk = 1'b0;
    always #10 adc_clk = ~adc_clk;  // 20 ns period

    adc_acq_top dut0 (
        .adc_clk     (adc_clk),
        .arst_n      (arst_n),
        .sample_in   (sample_in),
        .acq_enable  (acq_enable),
        .acq_trig    (acq_trig),
        .cfg         (cfg),
        .fill_num_wr (fill_num_wr),
        .pre_trig    (pre_trig),
        .out_word    (out_word),
        .out_valid   (out_valid),
        .fill_num    (fill_num),
        .acq_enabled (acq_enabled),
        .acq_done    (acq_done),
        .sm_idle     (sm_idle)
    );

    //////////////////////////////////////////////////
    // helpers

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("run aborted at %0d ns: %s", $time, why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic next_cycle();
        @(posedge adc_clk);
        #2;     // inputs move just after the edge
    endtask

    // ramp rule, sample0 = 2*idx and sample1 = 2*idx+1, both mod 4096
    function automatic logic [31:0] expected_lane(input logic [15:0] idx);
        acq_pkg::sample_pair_t p;
        p.sample0 = 12'((2 * idx) % 4096);
        p.sample1 = 12'((2 * idx + 1) % 4096);
        p.ovr0    = ovr_rec[idx][0];
        p.ovr1    = ovr_rec[idx][1];
        return {6'b0, p};   // zero-extended lane
    endfunction

    task automatic drive_pair();
        int r;
        r = $random(seed);
        ovr_rec[ramp_idx]   = r[1:0];
        sample_in.sample0   = 12'((2 * ramp_idx) % 4096);
        sample_in.sample1   = 12'((2 * ramp_idx + 1) % 4096);
        sample_in.ovr0      = r[0];
        sample_in.ovr1      = r[1];
    endtask

    task automatic wait_enabled(input logic level);
        int n;
        n = 0;
        while (acq_enabled !== level && n < 10) begin
            @(negedge adc_clk);     // acq_enabled only moves on posedge
            n++;
        end
        if (acq_enabled !== level) abort_run("acq_enabled never followed acq_enable");
    endtask

    task automatic pulse_trigger(input int spacing);
        acq_trig = 1'b1;
        repeat (4) next_cycle();    // long enough for the synchronizer
        acq_trig = 1'b0;
        repeat (spacing - 4) next_cycle();
    endtask

    //////////////////////////////////////////////////
    // ramp source
    always @(negedge adc_clk) en_seen <= acq_enabled;

    initial begin
        seed     = 32'h196a7c3d;
        ramp_idx = '0;
        drive_pair();
        forever begin
            next_cycle();
            if (en_seen) begin      // pair was taken at this edge
                ramp_idx = ramp_idx + 1'b1;
                drive_pair();
            end
        end
    end

    //////////////////////////////////////////////////
    // output monitor, samples mid cycle
    always @(negedge adc_clk) begin
        if (arst_n) begin
            if (out_valid) begin
                assert (fill_open) else report_error("output word outside a fill");
                assert (out_word.tag == acq_pkg::tag_wfm_hdr || out_word.tag == acq_pkg::tag_data)
                    else report_error($sformatf("unknown tag %h", out_word.tag));
                if (out_word.tag == acq_pkg::tag_wfm_hdr) begin
                    hdr = out_word.payload;
                    assert (data_left == 0 && hdr_cnt < exp_ntrig)
                        else report_error($sformatf("header with %0d words due, %0d headers seen",
                                                    data_left, hdr_cnt));
                    assert (hdr.rsvd == '0 && hdr.channel_tag == exp_ch && hdr.num_bursts == exp_nb)
                        else report_error($sformatf("header fields wrong %h", out_word.payload));
                    assert (hdr.fill_num == exp_fill)
                        else report_error($sformatf("header fill_num %h, expected %h",
                                                    hdr.fill_num, exp_fill));
                    assert (hdr.wfm_num == 12'(hdr_cnt))
                        else report_error($sformatf("wfm_num %0d, expected %0d", hdr.wfm_num, hdr_cnt));
                    if (hdr_cnt == 0) begin
                        trig_ofs = hdr.trig_addr - trig_ref;    // about seven edges of sync
                        assert (trig_ofs >= 16'd5 && trig_ofs <= 16'd9)
                            else report_error($sformatf("first trig_addr %0d, trigger near %0d",
                                                        hdr.trig_addr, trig_ref));
                    end else begin
                        trig_ofs = hdr.trig_addr - last_trig;
                        assert (trig_ofs == 16'(exp_spacing))
                            else report_error($sformatf("trig_addr step %0d, expected %0d",
                                                        trig_ofs, exp_spacing));
                    end
                    last_trig = hdr.trig_addr;
                    next_idx  = hdr.trig_addr - exp_pre;    // wraps with the buffer
                    data_left = exp_nb;
                    hdr_cnt++;
                end else if (out_word.tag == acq_pkg::tag_data) begin
                    // oldest pair in the lowest lane
                    exp_payload = {expected_lane(next_idx + 16'd3), expected_lane(next_idx + 16'd2),
                                   expected_lane(next_idx + 16'd1), expected_lane(next_idx)};
                    assert (data_left > 0) else report_error("data word without a pending header");
                    assert (out_word.payload == exp_payload)
                        else report_error($sformatf("data at ramp index %0d is %h, expected %h",
                                                    next_idx, out_word.payload, exp_payload));
                    next_idx = next_idx + 16'd4;
                    data_left--;
                end
            end
            if (acq_done) begin
                assert (fill_open && data_left == 0 && hdr_cnt == exp_ntrig)
                    else report_error($sformatf("acq_done with %0d of %0d waveforms, %0d words due",
                                                hdr_cnt, exp_ntrig, data_left));
                fill_open = 1'b0;
                done_cnt++;
            end
        end
    end

    //////////////////////////////////////////////////
    // one fill per case line
    task automatic run_case(input logic [11:0] ch, input logic [23:0] fill0,
                            input logic [13:0] nb, input logic [15:0] pre,
                            input int ntrig, input int spacing);
        int          n;
        int          start_done;
        int          limit;
        logic [23:0] fill_next;
        fill_next            = fill0 + 1'b1;
        cfg.channel_tag      = ch;
        cfg.num_bursts       = nb;
        cfg.initial_fill_num = fill0;
        pre_trig             = pre;
        fill_num_wr          = 1'b1;    // one cycle strobe
        next_cycle();
        fill_num_wr          = 1'b0;
        next_cycle();
        assert (fill_num == fill0)
            else report_error($sformatf("fill_num %h after load, expected %h", fill_num, fill0));

        exp_ch      = ch;
        exp_nb      = nb;
        exp_pre     = pre;
        exp_spacing = spacing;
        exp_ntrig   = ntrig;
        exp_fill    = fill0;
        hdr_cnt     = 0;
        data_left   = 0;
        fill_open   = 1'b1;
        start_done  = done_cnt;

        // trigger with acquisition off must vanish
        pulse_trigger(16);
        repeat (16) next_cycle();
        assert (hdr_cnt == 0 && sm_idle) else report_error("trigger while disabled made a waveform");

        acq_enable = 1'b1;
        wait_enabled(1'b1);
        repeat (300) next_cycle();  // fill the pre-trigger history
        @(negedge adc_clk);
        trig_ref = ramp_idx;
        next_cycle();
        repeat (ntrig) pulse_trigger(spacing);
        acq_enable = 1'b0;
        wait_enabled(1'b0);

        limit = ntrig * (5 * nb + 12) + 200;
        n = 0;
        while (done_cnt == start_done && n < limit) begin
            @(posedge adc_clk);     // monitor counts on negedge
            n++;
        end
        if (done_cnt == start_done) abort_run("acq_done never pulsed after the last waveform");
        #2;
        assert (fill_num == fill_next)
            else report_error($sformatf("fill_num %h after fill end, expected %h", fill_num, fill_next));
        repeat (30) next_cycle();
        assert (done_cnt == start_done + 1 && sm_idle && !out_valid)
            else report_error($sformatf("%0d acq_done pulses in one fill", done_cnt - start_done));
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        int          fd;
        int          code;
        int          ncases;
        string       line;
        logic [11:0] c_ch;
        logic [23:0] c_fill;
        int          c_nb;
        int          c_pre;
        int          c_ntrig;
        int          c_spacing;
        done_cnt    = 0;
        hdr_cnt     = 0;
        data_left   = 0;
        exp_ntrig   = 0;
        fill_open   = 1'b0;
        arst_n      = 1'b0;
        acq_enable  = 1'b0;
        acq_trig    = 1'b0;
        cfg         = '0;
        fill_num_wr = 1'b0;
        pre_trig    = '0;

        @(negedge adc_clk);
        assert (!out_valid && !acq_done && sm_idle && !acq_enabled && fill_num == '0)
            else report_error("outputs not at reset values during reset");
        repeat (8) @(posedge adc_clk);
        #2 arst_n = 1'b1;
        repeat (5) next_cycle();
        assert (!out_valid && !acq_done && sm_idle && !acq_enabled && fill_num == '0)
            else report_error("outputs not idle after reset");

        fd = $fopen("bench/acq_cases.txt", "r");
        if (fd == 0) abort_run("cannot open bench/acq_cases.txt");
        code = $fgets(line, fd);    // two column lines on top
        code = $fgets(line, fd);
        ncases = 0;
        code = $fscanf(fd, "%h %h %d %d %d %d", c_ch, c_fill, c_nb, c_pre, c_ntrig, c_spacing);
        while (code == 6) begin
            run_case(c_ch, c_fill, 14'(c_nb), 16'(c_pre), c_ntrig, c_spacing);
            ncases++;
            code = $fscanf(fd, "%h %h %d %d %d %d", c_ch, c_fill, c_nb, c_pre, c_ntrig, c_spacing);
        end
        $fclose(fd);
        if (ncases == 0) abort_run("no test case found in bench/acq_cases.txt");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- bench/acq_cases.txt
// channel_tag(hex) initial_fill_num(hex) num_bursts pre_trig trigger_count spacing_cycles
// keep 4*num_bursts - pre_trig below spacing - 3 so reads stay behind writes
3A1 000100  4    8  3  40
0F0 00ABCD  1    0  1  20
FFF FFFFFF  8   20  5  50
123 000010 16  100  8  30
555 000000  2    3 16  12
ABC 123456 32  250  2 200
001 000200  0    0  4  16
7E7 00FFFF 12   40  4  64
2C4 000300  3    1  6  24
9A0 0F0F0F  6   60 10  36

//--- tb.f
verilog/acq_pkg.sv
verilog/acq_ctrl_sync.sv
verilog/sample_cbuf.sv
verilog/trig_addr_fifo.sv
verilog/readout_sm.sv
verilog/word_pack.sv
verilog/adc_acq_top.sv
bench/tb_adc_acq.sv
